// ==== Bender.yml ====
package:
  name: pe_array

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/pe_array_pkg.sv
      - hdl/mac_pe.sv
      - hdl/sum_tree.sv
      - hdl/bias_regs.sv
      - hdl/input_buffer.sv
      - hdl/pe_grid.sv
      - hdl/output_packer.sv
      - hdl/pe_array.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/pe_array_assertions.sv
      - testbench/tb_pe_array.sv

// ==== flist.f ====
+incdir+hdl
hdl/pe_array_pkg.sv
hdl/mac_pe.sv
hdl/sum_tree.sv
hdl/bias_regs.sv
hdl/input_buffer.sv
hdl/pe_grid.sv
hdl/output_packer.sv
hdl/pe_array.sv
testbench/pe_array_assertions.sv
testbench/tb_pe_array.sv

// ==== hdl/bias_regs.sv ====
`timescale 1ns/1ps
`include "pe_array_cfg.svh"

module bias_regs import pe_array_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  bias_cmd_t bias_cmd,
	output acc_vec_t  bias
);

	localparam int BYTE_W = 8;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			bias <= '0;
		end else if (bias_cmd.wr) begin
			for (int m = 0; m < `PE_N_DIM; m++) begin
				bias[m][bias_cmd.addr*BYTE_W +: BYTE_W] <= bias_cmd.data[m]; // Other lanes hold
			end
		end
	end

endmodule

// ==== hdl/input_buffer.sv ====
`timescale 1ns/1ps
`include "pe_array_cfg.svh"

module input_buffer import pe_array_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  act_cmd_t act_cmd,
	output act_vec_t acts
);

	act_vec_t shifted;

	// Elements move one place toward index 0 and the new value enters at the top
	always_comb begin
		for (int j = 0; j < `PE_N_DIM - 1; j++) begin
			shifted[j] = acts[j + 1];
		end
		shifted[`PE_N_DIM-1] = act_cmd.data[0];
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			acts <= '0;
		end else if (act_cmd.load) begin
			acts <= act_cmd.data; // Load wins over shift
		end else if (act_cmd.shift) begin
			acts <= shifted;
		end
	end

endmodule

// ==== hdl/mac_pe.sv ====
`timescale 1ns/1ps

module mac_pe import pe_array_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  logic    clear,
	input  logic    step,
	input  act_t    act,
	input  weight_t weight,
	output acc_t    acc
);

	acc_t product;

	// Both operands are signed, so the product is sign extended to the accumulator width
	assign product = act * weight;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			acc <= '0;
		end else if (clear) begin
			acc <= '0; // Clear takes priority and drops this cycle's product
		end else if (step) begin
			acc <= acc + product;
		end
	end

endmodule

// ==== hdl/output_packer.sv ====
`timescale 1ns/1ps
`include "pe_array_cfg.svh"

module output_packer import pe_array_pkg::*; (
	input  logic                   clk,
	input  logic                   reset,
	input  precision_t             precision,
	input  logic [`PE_SHIFT_W-1:0] shift,
	input  logic                   emit,
	input  logic                   done_layer,
	input  acc_vec_t               sums,
	output logic                   out_valid,
	output act_vec_t               out_data
);

	localparam acc_t ACT_MAX = (1 <<< (`PE_ACT_W - 1)) - 1;
	localparam acc_t ACT_MIN = -(1 <<< (`PE_ACT_W - 1));
	localparam int NIB_W = `PE_ACT_W / 2;

	act_vec_t quant;
	act_vec_t packed_vec;
	act_vec_t stored;
	logic     pending;

	function automatic act_t saturate(acc_t value);
		if (value > ACT_MAX) begin
			return act_t'(ACT_MAX);
		end
		if (value < ACT_MIN) begin
			return act_t'(ACT_MIN);
		end
		return act_t'(value);
	endfunction

	always_comb begin
		for (int m = 0; m < `PE_N_DIM; m++) begin
			quant[m] = saturate(sums[m] >>> shift); // Arithmetic shift keeps the sign
			packed_vec[m] = {quant[m][NIB_W-1:0], stored[m][NIB_W-1:0]}; // Newer result on top
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			out_valid <= 1'b0;
			out_data  <= '0;
			pending   <= 1'b0;
			stored    <= '0;
		end else begin
			out_valid <= 1'b0;
			if (done_layer) begin
				pending <= 1'b0; // A half-filled pack is dropped
			end else if (emit) begin
				if (precision == PREC_8) begin
					out_valid <= 1'b1;
					out_data  <= quant;
				end else if (!pending) begin
					pending <= 1'b1;
					stored  <= quant;
				end else begin
					pending   <= 1'b0;
					out_valid <= 1'b1;
					out_data  <= packed_vec;
				end
			end
		end
	end

endmodule

// ==== hdl/pe_array.sv ====
`timescale 1ns/1ps

module pe_array import pe_array_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  layer_cfg_t layer_cfg,
	input  act_cmd_t   act_cmd,
	input  bias_cmd_t  bias_cmd,
	input  step_cmd_t  step_cmd,
	input  logic       emit,
	input  logic       done_layer,
	output logic       out_valid,
	output act_vec_t   out_data
);

	act_vec_t acts;
	acc_vec_t bias;
	acc_vec_t sums;

	input_buffer u_input_buffer (
		.clk    (clk),
		.reset  (reset),
		.act_cmd(act_cmd),
		.acts   (acts)
	);

	bias_regs u_bias_regs (
		.clk     (clk),
		.reset   (reset),
		.bias_cmd(bias_cmd),
		.bias    (bias)
	);

	pe_grid u_pe_grid (
		.clk     (clk),
		.reset   (reset),
		.mode    (layer_cfg.mode),
		.step_cmd(step_cmd),
		.acts    (acts),
		.bias    (bias),
		.sums    (sums)
	);

	// Sums are combinational, so an emit sees every step issued before it
	output_packer u_output_packer (
		.clk       (clk),
		.reset     (reset),
		.precision (layer_cfg.precision),
		.shift     (layer_cfg.shift),
		.emit      (emit),
		.done_layer(done_layer),
		.sums      (sums),
		.out_valid (out_valid),
		.out_data  (out_data)
	);

endmodule

// ==== hdl/pe_array_cfg.svh ====
`ifndef PE_ARRAY_CFG_SVH
`define PE_ARRAY_CFG_SVH

// Grid is PE_N_DIM by PE_N_DIM elements
`define PE_N_DIM 4

// Activations and packed outputs share one width
`define PE_ACT_W 8

`define PE_WEIGHT_W 8

// Accumulators and biases
`define PE_ACC_W 32

// Byte lanes needed to load one bias
`define PE_BIAS_BYTES 4

`define PE_SHIFT_W 5

`endif

// ==== hdl/pe_array_pkg.sv ====
`include "pe_array_cfg.svh"

package pe_array_pkg;

	typedef enum logic {
		MODE_FC,
		MODE_CNN
	} mode_t;

	typedef enum logic {
		PREC_8,
		PREC_4
	} precision_t;

	typedef logic signed [`PE_ACT_W-1:0] act_t;
	typedef logic signed [`PE_WEIGHT_W-1:0] weight_t;
	typedef logic signed [`PE_ACC_W-1:0] acc_t;

	typedef act_t [`PE_N_DIM-1:0] act_vec_t;
	typedef acc_t [`PE_N_DIM-1:0] acc_vec_t;
	typedef weight_t [`PE_N_DIM-1:0][`PE_N_DIM-1:0] weight_mat_t; // Indexed [row][column]

	typedef struct packed {
		mode_t                  mode;
		precision_t             precision;
		logic [`PE_SHIFT_W-1:0] shift;
	} layer_cfg_t;

	typedef struct packed {
		logic     load;
		logic     shift;
		act_vec_t data;
	} act_cmd_t;

	typedef struct packed {
		logic                             wr;
		logic [$clog2(`PE_BIAS_BYTES)-1:0] addr; // Byte lane written in every bias
		act_vec_t                         data;
	} bias_cmd_t;

	typedef struct packed {
		logic        step;
		logic        clear;
		weight_mat_t weights;
	} step_cmd_t;

endpackage

// ==== hdl/pe_grid.sv ====
`timescale 1ns/1ps
`include "pe_array_cfg.svh"

module pe_grid import pe_array_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  mode_t     mode,
	input  step_cmd_t step_cmd,
	input  act_vec_t  acts,
	input  acc_vec_t  bias,
	output acc_vec_t  sums
);

	weight_mat_t pe_weights;
	acc_vec_t    row_accs [`PE_N_DIM];
	acc_vec_t    col_accs [`PE_N_DIM];
	acc_vec_t    tree_in [`PE_N_DIM];
	acc_t        tree_sum [`PE_N_DIM];

	genvar i, j;

	generate
		for (i = 0; i < `PE_N_DIM; i++) begin : g_row
			for (j = 0; j < `PE_N_DIM; j++) begin : g_col
				// In CNN mode the whole row shares the weight of column 0
				assign pe_weights[i][j] = (mode == MODE_FC) ? step_cmd.weights[i][j]
				                                            : step_cmd.weights[i][0];
				assign col_accs[j][i] = row_accs[i][j];

				mac_pe u_pe (
					.clk   (clk),
					.reset (reset),
					.clear (step_cmd.clear),
					.step  (step_cmd.step),
					.act   (acts[j]),
					.weight(pe_weights[i][j]),
					.acc   (row_accs[i][j])
				);
			end
		end

		for (i = 0; i < `PE_N_DIM; i++) begin : g_tree
			assign tree_in[i] = (mode == MODE_FC) ? row_accs[i] : col_accs[i];

			sum_tree u_tree (
				.operands(tree_in[i]),
				.sum     (tree_sum[i])
			);

			assign sums[i] = (mode == MODE_CNN) ? tree_sum[i] + bias[i] : tree_sum[i];
		end
	endgenerate

endmodule

// ==== hdl/sum_tree.sv ====
`timescale 1ns/1ps
`include "pe_array_cfg.svh"

module sum_tree import pe_array_pkg::*; (
	input  acc_vec_t operands,
	output acc_t     sum
);

	// Heap layout: leaves sit at N..2N-1 and node k adds its two children
	acc_t node [1:2*`PE_N_DIM-1];

	genvar k;

	generate
		for (k = 0; k < `PE_N_DIM; k++) begin : g_leaf
			assign node[`PE_N_DIM + k] = operands[k];
		end

		for (k = 1; k < `PE_N_DIM; k++) begin : g_node
			assign node[k] = node[2*k] + node[2*k + 1];
		end
	endgenerate

	assign sum = node[1];

endmodule

// ==== testbench/pe_array_assertions.sv ====
`timescale 1ns/1ps

module pe_array_assertions import pe_array_pkg::*; (
	input logic     clk,
	input logic     reset,
	input logic     emit,
	input logic     out_valid,
	input act_vec_t out_data
);

	int unsigned failure_count = 0; // Failed assertions so far

	// Every output answers an emit from the cycle before
	valid_follows_emit: assert property (@(posedge clk) disable iff (!reset)
		out_valid |-> $past(emit))
		else begin
			failure_count++;
			$error("out_valid without an emit in the previous cycle");
		end

	back_to_back_valid: assert property (@(posedge clk) disable iff (!reset)
		(out_valid && $past(out_valid)) |-> ($past(emit) && $past(emit, 2)))
		else begin
			failure_count++;
			$error("out_valid high twice in a row without two emits before it");
		end

	no_unknown_outputs: assert property (@(posedge clk) disable iff (!reset)
		!$isunknown({out_valid, out_data}))
		else begin
			failure_count++;
			$error("out_valid or out_data unknown after reset");
		end

endmodule

bind pe_array pe_array_assertions u_assertions (
	.clk      (clk),
	.reset    (reset),
	.emit     (emit),
	.out_valid(out_valid),
	.out_data (out_data)
);

// ==== testbench/tb_pe_array.sv ====
`timescale 1ns/1ps
`include "pe_array_cfg.svh"

module tb_pe_array import pe_array_pkg::*; ();

	logic       clk;
	logic       reset;
	layer_cfg_t layer_cfg;
	act_cmd_t   act_cmd;
	bias_cmd_t  bias_cmd;
	step_cmd_t  step_cmd;
	logic       emit;
	logic       done_layer;
	logic       out_valid;
	act_vec_t   out_data;

	act_t     act_m [`PE_N_DIM];
	acc_t     bias_m [`PE_N_DIM];
	acc_t     acc_m [`PE_N_DIM][`PE_N_DIM];
	act_vec_t stored_m;
	logic     pending_m;
	act_vec_t expected_q [$];

	pe_array u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Result: FAILED");
		$fatal(1, "stopping at the first error");
	endtask

	// Saturated, shifted row sums in FC mode and column sums plus bias in CNN mode
	function automatic act_vec_t expected_vec(input mode_t mode, input logic [4:0] shift);
		acc_t     sum;
		acc_t     shifted;
		act_vec_t res;
		for (int k = 0; k < `PE_N_DIM; k++) begin
			sum = (mode == MODE_CNN) ? bias_m[k] : '0;
			for (int i = 0; i < `PE_N_DIM; i++) begin
				sum = sum + ((mode == MODE_FC) ? acc_m[k][i] : acc_m[i][k]);
			end
			shifted = sum >>> shift;
			if (shifted > 127) res[k] = act_t'(127);
			else if (shifted < -128) res[k] = act_t'(-128);
			else res[k] = act_t'(shifted);
		end
		return res;
	endfunction

	function automatic act_vec_t random_acts();
		act_vec_t v;
		for (int j = 0; j < `PE_N_DIM; j++) v[j] = act_t'($urandom);
		return v;
	endfunction

	function automatic weight_mat_t random_weights();
		weight_mat_t w;
		for (int i = 0; i < `PE_N_DIM; i++) begin
			for (int j = 0; j < `PE_N_DIM; j++) w[i][j] = weight_t'($urandom);
		end
		return w;
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#1;
		act_cmd.load = 1'b0; // Every strobe lasts exactly one cycle
		act_cmd.shift = 1'b0;
		bias_cmd.wr = 1'b0;
		step_cmd.step = 1'b0;
		step_cmd.clear = 1'b0;
		emit = 1'b0;
		done_layer = 1'b0;
	endtask

	task automatic set_layer(input mode_t mode, input precision_t prec, input int shift);
		layer_cfg = '{mode: mode, precision: prec, shift: shift[4:0]};
		next_cycle();
	endtask

	task automatic load_acts(input act_vec_t data);
		act_cmd.load = 1'b1;
		act_cmd.data = data;
		for (int j = 0; j < `PE_N_DIM; j++) act_m[j] = data[j];
		next_cycle();
	endtask

	task automatic shift_act(input act_t value);
		act_cmd.shift = 1'b1;
		act_cmd.data = '0;
		act_cmd.data[0] = value;
		for (int j = 0; j < `PE_N_DIM - 1; j++) act_m[j] = act_m[j + 1];
		act_m[`PE_N_DIM-1] = value;
		next_cycle();
	endtask

	task automatic write_bias(input int lane, input act_vec_t data);
		bias_cmd.wr = 1'b1;
		bias_cmd.addr = lane[1:0];
		bias_cmd.data = data;
		for (int m = 0; m < `PE_N_DIM; m++) bias_m[m][lane*8 +: 8] = data[m];
		next_cycle();
	endtask

	task automatic run_step(input weight_mat_t w, input logic clear);
		weight_t w_sel;
		step_cmd.step = 1'b1;
		step_cmd.clear = clear;
		step_cmd.weights = w;
		for (int i = 0; i < `PE_N_DIM; i++) begin
			for (int j = 0; j < `PE_N_DIM; j++) begin
				w_sel = (layer_cfg.mode == MODE_FC) ? w[i][j] : w[i][0];
				if (clear) begin
					acc_m[i][j] = '0;
				end else begin
					acc_m[i][j] = acc_m[i][j] + act_m[j] * w_sel;
				end
			end
		end
		next_cycle();
	endtask

	task automatic emit_once();
		act_vec_t q;
		act_vec_t packed_vec;
		q = expected_vec(layer_cfg.mode, layer_cfg.shift);
		if (layer_cfg.precision == PREC_8) begin
			expected_q.push_back(q);
		end else if (!pending_m) begin
			stored_m = q;
			pending_m = 1'b1;
		end else begin
			for (int m = 0; m < `PE_N_DIM; m++) packed_vec[m] = {q[m][3:0], stored_m[m][3:0]};
			expected_q.push_back(packed_vec);
			pending_m = 1'b0;
		end
		emit = 1'b1;
		next_cycle();
	endtask

	task automatic end_layer();
		done_layer = 1'b1;
		pending_m = 1'b0;
		next_cycle();
	endtask

	task automatic wait_drained();
		int waited;
		waited = 0;
		while (expected_q.size() != 0 && waited < 20) begin
			@(negedge clk);
			waited++;
		end
		if (expected_q.size() != 0) report_failure("timed out waiting for out_valid");
	endtask

	always @(negedge clk) begin : compare
		act_vec_t exp_vec;
		assert (u_dut.u_assertions.failure_count == 0)
			else report_failure("a bound protocol assertion failed");
		if (reset && out_valid) begin
			assert (expected_q.size() != 0)
				else report_failure("out_valid went high with no result expected");
			exp_vec = expected_q.pop_front();
			assert (out_data == exp_vec)
				else report_failure($sformatf("mismatch out_data: got %h expected %h",
					out_data, exp_vec));
		end
	end

	initial begin
		weight_mat_t big_w;
		acc_t        bias_val [`PE_N_DIM];
		act_vec_t    lane_data;
		void'($urandom(63599));
		reset = 1'b0;
		layer_cfg = '{mode: MODE_FC, precision: PREC_8, shift: 5'd0};
		act_cmd = '0;
		bias_cmd = '0;
		step_cmd = '0;
		emit = 1'b0;
		done_layer = 1'b0;
		pending_m = 1'b0;
		stored_m = '0;
		for (int i = 0; i < `PE_N_DIM; i++) begin
			act_m[i] = '0;
			bias_m[i] = '0;
			for (int j = 0; j < `PE_N_DIM; j++) acc_m[i][j] = '0;
		end
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b1;

		assert (out_valid == 1'b0)
			else report_failure($sformatf("mismatch out_valid: got %h expected 0", out_valid));
		assert (out_data == '0)
			else report_failure($sformatf("mismatch out_data: got %h expected 0", out_data));
		repeat (3) next_cycle();
		emit_once();
		wait_drained();

		set_layer(MODE_FC, PREC_8, 8);
		repeat (4) begin
			load_acts(random_acts());
			run_step(random_weights(), 1'b0);
			emit_once();
		end
		wait_drained();

		set_layer(MODE_CNN, PREC_8, 10);
		run_step(random_weights(), 1'b1);
		for (int m = 0; m < `PE_N_DIM; m++) begin
			bias_val[m] = acc_t'($urandom_range(32767)) - 16384; // Small, so column sums still show
		end
		for (int b = 0; b < `PE_BIAS_BYTES; b++) begin
			for (int m = 0; m < `PE_N_DIM; m++) lane_data[m] = bias_val[m][b*8 +: 8];
			write_bias(b, lane_data);
		end
		for (int j = 0; j < `PE_N_DIM; j++) shift_act(act_t'($urandom));
		repeat (3) run_step(random_weights(), 1'b0);
		emit_once();
		wait_drained();

		run_step(random_weights(), 1'b1); // Clear wins over the step in the same cycle
		emit_once();
		emit_once();
		emit_once();
		run_step(random_weights(), 1'b0);
		emit_once();
		emit_once();
		wait_drained();

		set_layer(MODE_FC, PREC_4, 12);
		load_acts(random_acts());
		run_step(random_weights(), 1'b0);
		emit_once();
		run_step(random_weights(), 1'b0);
		emit_once();
		emit_once();
		end_layer(); // The lone half pack is dropped here
		run_step(random_weights(), 1'b0);
		emit_once();
		emit_once();
		wait_drained();

		set_layer(MODE_FC, PREC_8, 0);
		run_step(random_weights(), 1'b1);
		load_acts({`PE_N_DIM{act_t'(127)}});
		for (int i = 0; i < `PE_N_DIM; i++) begin
			for (int j = 0; j < `PE_N_DIM; j++) big_w[i][j] = (i < 2) ? 8'sd127 : -8'sd128;
		end
		repeat (2) run_step(big_w, 1'b0);
		emit_once();
		wait_drained();

		if (u_dut.u_assertions.failure_count == 0) begin
			$display("Result: PASSED");
			$finish;
		end else begin
			report_failure("a bound protocol assertion failed");
		end
	end

endmodule
